// File: files.f
hdl/dispatch_cfg_pkg.sv
hdl/thread_ctx_pkg.sv
hdl/thread_fifo.sv
hdl/rt_dispatch.sv
hdl/ic_dispatch.sv
hdl/patch_tracker.sv
hdl/patch_dispatcher.sv
bench/patch_dispatcher_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the patch dispatcher testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f \
    --top-module patch_dispatcher_tb -o patch_dispatcher_sim > build.log 2>&1 \
    && ./obj_dir/patch_dispatcher_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; }
echo "simulation passed"
exit 0

// File: bench/dispatch_trace.txt
# T name | L count first_pixel_hex | E tid rt_core ack_delay | I tid ic_core
# S rt_mask_hex (switch) | D rt_mask_hex (done) | J ic_core (ic return) | P (patch_done)
T load_order
L 16 a000
E 0 0 0
E 1 1 0
T back_pressure
E 2 2 3
E 3 3 0
T multi_switch
S 6
E 4 1 0
E 5 2 0
I 1 0
I 2 1
T ic_return
J 0
J 1
D f
E 6 0 0
E 7 1 0
E 8 2 0
E 9 3 0
D f
E 10 0 0
E 11 1 0
E 12 2 0
E 13 3 0
D f
E 14 0 0
E 15 1 0
E 1 2 0
E 2 3 0
T completion
D f
P
T second_patch
L 4 b000
E 0 0 0
E 1 1 0
E 2 2 2
E 3 3 0
D f
P

// File: bench/patch_dispatcher_tb.sv
`timescale 1ns/1ps

module patch_dispatcher_tb;

    logic clk;
    logic rst_n;
    logic load_valid;
    logic load_last;
    thread_ctx_pkg::pixel_id_t  load_pixel;
    thread_ctx_pkg::rt_mask_t   rt_req;
    thread_ctx_pkg::thread_id_t rt_tid;
    thread_ctx_pkg::pixel_id_t  rt_pixel;
    thread_ctx_pkg::addr_t      rt_pc;
    thread_ctx_pkg::addr_t      rt_sp;
    thread_ctx_pkg::rt_mask_t   rt_ack;
    thread_ctx_pkg::rt_mask_t   rt_done;
    thread_ctx_pkg::rt_mask_t   rt_switch;
    thread_ctx_pkg::thread_id_t rt_ret_tid [dispatch_cfg_pkg::num_rt];
    thread_ctx_pkg::addr_t      rt_ret_pc  [dispatch_cfg_pkg::num_rt];
    thread_ctx_pkg::addr_t      rt_ret_sp  [dispatch_cfg_pkg::num_rt];
    thread_ctx_pkg::ic_mask_t   ic_req;
    thread_ctx_pkg::thread_id_t ic_tid;
    thread_ctx_pkg::ic_mask_t   ic_ack;
    thread_ctx_pkg::ic_mask_t   ic_switch;
    thread_ctx_pkg::thread_id_t ic_ret_tid [dispatch_cfg_pkg::num_ic];
    logic patch_done;

    // reference model of the loaded patch
    thread_ctx_pkg::pixel_id_t  pix_m [dispatch_cfg_pkg::num_thread];
    thread_ctx_pkg::addr_t      pc_m  [dispatch_cfg_pkg::num_thread];
    thread_ctx_pkg::addr_t      sp_m  [dispatch_cfg_pkg::num_thread];
    thread_ctx_pkg::thread_id_t rt_held [dispatch_cfg_pkg::num_rt];
    thread_ctx_pkg::thread_id_t ic_held [dispatch_cfg_pkg::num_ic];

    string kind_q[$];
    string name_q[$];
    int    a_q[$];
    int    b_q[$];
    int    c_q[$];
    string cur_test = "";
    int    errors = 0;
    int    test_errors = 0;
    int    checks = 0;
    int    pulses = 0;
    int    pulse_target = 0;
    int    cycles = 0;
    int    cycle_limit = 0;

    patch_dispatcher patch_dispatcher_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles in test %s", cycle_limit, cur_test);
            $display("Checks failed");
            $finish;
        end
    end

    // advance to 1 ns past the next rising edge
    task automatic step();
        @(posedge clk);
        #1;
        if (patch_done) pulses++;
    endtask

    task automatic report_mismatch(string sig, logic [31:0] exp_v, logic [31:0] got_v);
        $display("ERR t=%0t %s exp %0h got %0h", $time, sig, exp_v, got_v);
        errors++;
        test_errors++;
    endtask

    task automatic check_rt(thread_ctx_pkg::rt_mask_t exp_mask,
                            thread_ctx_pkg::thread_id_t exp_tid,
                            thread_ctx_pkg::pixel_id_t exp_pix, thread_ctx_pkg::addr_t exp_pc,
                            thread_ctx_pkg::addr_t exp_sp);
        checks++;
        if (rt_req !== exp_mask) report_mismatch("rt_req", 32'(exp_mask), 32'(rt_req));
        if (rt_tid !== exp_tid) report_mismatch("rt_tid", 32'(exp_tid), 32'(rt_tid));
        if (rt_pixel !== exp_pix) report_mismatch("rt_pixel", exp_pix, rt_pixel);
        if (rt_pc !== exp_pc) report_mismatch("rt_pc", exp_pc, rt_pc);
        if (rt_sp !== exp_sp) report_mismatch("rt_sp", exp_sp, rt_sp);
    endtask

    task automatic check_ic(thread_ctx_pkg::ic_mask_t exp_mask,
                            thread_ctx_pkg::thread_id_t exp_tid);
        checks++;
        if (ic_req !== exp_mask) report_mismatch("ic_req", 32'(exp_mask), 32'(ic_req));
        if (ic_tid !== exp_tid) report_mismatch("ic_tid", 32'(exp_tid), 32'(ic_tid));
    endtask

    task automatic check_done(logic exp_v);
        checks++;
        if (patch_done !== exp_v) report_mismatch("patch_done", 32'(exp_v), 32'(patch_done));
    endtask

    // no request may stay raised once every thread is retired
    task automatic check_idle();
        checks++;
        if (rt_req !== '0) report_mismatch("rt_req", 32'h0, 32'(rt_req));
        if (ic_req !== '0) report_mismatch("ic_req", 32'h0, 32'(ic_req));
    endtask

    task automatic load_patch(int n, int base);
        for (int t = 0; t < n; t++) begin
            pix_m[t]   = 32'(base + t);
            pc_m[t]    = 32'h0;
            sp_m[t]    = dispatch_cfg_pkg::sp_base + (32'(t) << 16);
            load_valid = 1'b1;
            load_last  = (t == n - 1);
            load_pixel = pix_m[t];
            step();
        end
        load_valid = 1'b0;
        load_last  = 1'b0;
    endtask

    task automatic serve_rt(int tid, int core, int delay);
        thread_ctx_pkg::rt_mask_t exp_mask;
        exp_mask = thread_ctx_pkg::rt_mask_t'(1 << core);
        while (rt_req == '0) step();
        check_rt(exp_mask, 4'(tid), pix_m[tid], pc_m[tid], sp_m[tid]);
        // request and data hold while the core delays its ack
        for (int n = 0; n < delay; n++) begin
            step();
            check_rt(exp_mask, 4'(tid), pix_m[tid], pc_m[tid], sp_m[tid]);
        end
        rt_ack[core] = 1'b1;
        step();
        while (rt_req[core]) step();
        rt_ack[core]  = 1'b0;
        rt_held[core] = 4'(tid);
    endtask

    task automatic serve_ic(int tid, int core);
        while (ic_req == '0) step();
        check_ic(thread_ctx_pkg::ic_mask_t'(1 << core), 4'(tid));
        ic_ack[core] = 1'b1;
        step();
        while (ic_req[core]) step();
        ic_ack[core]  = 1'b0;
        ic_held[core] = 4'(tid);
    endtask

    // switching thread saves a new pc and a lowered sp
    task automatic switch_rt(int mask);
        thread_ctx_pkg::thread_id_t tid;
        for (int i = 0; i < dispatch_cfg_pkg::num_rt; i++) begin
            if (mask[i]) begin
                tid           = rt_held[i];
                pc_m[tid]     = 32'h400 + (32'(tid) << 2);
                sp_m[tid]     = sp_m[tid] - 32'h40;
                rt_ret_tid[i] = tid;
                rt_ret_pc[i]  = pc_m[tid];
                rt_ret_sp[i]  = sp_m[tid];
            end
        end
        rt_switch = thread_ctx_pkg::rt_mask_t'(mask);
        step();
        rt_switch = '0;
    endtask

    task automatic return_ic(int core);
        ic_ret_tid[core] = ic_held[core];
        ic_switch[core]  = 1'b1;
        step();
        ic_switch = '0;
    endtask

    // the pulse follows the edge that brings the done count to the load count
    task automatic wait_patch_done();
        pulse_target++;
        check_done(1'b0);
        step();
        check_done(1'b1);
        step();
        check_done(1'b0);
    endtask

    task automatic close_test();
        if (cur_test != "") begin
            $display("test %s: %s (%0d errors)", cur_test, test_errors == 0 ? "ok" : "FAILED",
                     test_errors);
        end
        test_errors = 0;
    endtask

    task automatic read_trace();
        int fd;
        int a;
        int b;
        int c;
        string tok;
        string name;
        string line;
        fd = $fopen("bench/dispatch_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file bench/dispatch_trace.txt");
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            a = 0;
            b = 0;
            c = 0;
            name = "";
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(line, fd));
                continue;
            end
            case (tok)
                "T": void'($fscanf(fd, "%s", name));
                "L": void'($fscanf(fd, "%d %h", a, b));
                "E": void'($fscanf(fd, "%d %d %d", a, b, c));
                "I": void'($fscanf(fd, "%d %d", a, b));
                "S", "D": void'($fscanf(fd, "%h", a));
                "J": void'($fscanf(fd, "%d", a));
                default: ;
            endcase
            kind_q.push_back(tok);
            name_q.push_back(name);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_last  = 1'b0;
        load_pixel = '0;
        rt_ack     = '0;
        rt_done    = '0;
        rt_switch  = '0;
        ic_ack     = '0;
        ic_switch  = '0;
        for (int i = 0; i < dispatch_cfg_pkg::num_rt; i++) begin
            rt_ret_tid[i] = '0;
            rt_ret_pc[i]  = '0;
            rt_ret_sp[i]  = '0;
        end
        for (int i = 0; i < dispatch_cfg_pkg::num_ic; i++) ic_ret_tid[i] = '0;
        read_trace();
        cycle_limit = 40 * kind_q.size();
        if (kind_q.size() == 0) begin
            $display("trace file holds no records");
            errors++;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        for (int i = 0; i < kind_q.size(); i++) begin
            case (kind_q[i])
                "T": begin
                    close_test();
                    cur_test = name_q[i];
                end
                "L": load_patch(a_q[i], b_q[i]);
                "E": serve_rt(a_q[i], b_q[i], c_q[i]);
                "I": serve_ic(a_q[i], b_q[i]);
                "S": switch_rt(a_q[i]);
                "D": begin
                    rt_done = thread_ctx_pkg::rt_mask_t'(a_q[i]);
                    step();
                    rt_done = '0;
                end
                "J": return_ic(a_q[i]);
                "P": wait_patch_done();
                default: begin
                    $display("unknown trace record %s", kind_q[i]);
                    errors++;
                end
            endcase
        end
        repeat (4) step();
        check_idle();
        close_test();
        if (pulses != pulse_target) begin
            $display("patch_done pulsed %0d times, %0d expected", pulses, pulse_target);
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hdl/patch_dispatcher.sv
`timescale 1ns/1ps

module patch_dispatcher (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_valid,
    input  logic                       load_last,
    input  thread_ctx_pkg::pixel_id_t  load_pixel,
    output thread_ctx_pkg::rt_mask_t   rt_req,
    output thread_ctx_pkg::thread_id_t rt_tid,
    output thread_ctx_pkg::pixel_id_t  rt_pixel,
    output thread_ctx_pkg::addr_t      rt_pc,
    output thread_ctx_pkg::addr_t      rt_sp,
    input  thread_ctx_pkg::rt_mask_t   rt_ack,
    input  thread_ctx_pkg::rt_mask_t   rt_done,
    input  thread_ctx_pkg::rt_mask_t   rt_switch,
    input  thread_ctx_pkg::thread_id_t rt_ret_tid [dispatch_cfg_pkg::num_rt],
    input  thread_ctx_pkg::addr_t      rt_ret_pc  [dispatch_cfg_pkg::num_rt],
    input  thread_ctx_pkg::addr_t      rt_ret_sp  [dispatch_cfg_pkg::num_rt],
    output thread_ctx_pkg::ic_mask_t   ic_req,
    output thread_ctx_pkg::thread_id_t ic_tid,
    input  thread_ctx_pkg::ic_mask_t   ic_ack,
    input  thread_ctx_pkg::ic_mask_t   ic_switch,
    input  thread_ctx_pkg::thread_id_t ic_ret_tid [dispatch_cfg_pkg::num_ic],
    output logic                       patch_done
);

    logic                                loading;
    logic                                load_push;
    thread_ctx_pkg::thread_id_t          load_tid;
    thread_ctx_pkg::thread_id_t          ready_tid;
    logic                                susp_push;
    thread_ctx_pkg::thread_id_t          susp_tid;
    logic                                back_push;
    thread_ctx_pkg::thread_id_t          back_tid;
    logic                                ctx_write;
    thread_ctx_pkg::thread_id_t          ctx_tid;
    thread_ctx_pkg::addr_t               ctx_pc;
    thread_ctx_pkg::addr_t               ctx_sp;
    logic [dispatch_cfg_pkg::thread_w:0] done_count;

    rt_dispatch rt_dispatch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_push  (load_push),
        .load_tid   (load_tid),
        .loading    (loading),
        .back_push  (back_push),
        .back_tid   (back_tid),
        .rt_ack     (rt_ack),
        .rt_done    (rt_done),
        .rt_switch  (rt_switch),
        .rt_ret_tid (rt_ret_tid),
        .rt_ret_pc  (rt_ret_pc),
        .rt_ret_sp  (rt_ret_sp),
        .rt_req     (rt_req),
        .rt_tid     (rt_tid),
        .ready_tid  (ready_tid),
        .susp_push  (susp_push),
        .susp_tid   (susp_tid),
        .ctx_write  (ctx_write),
        .ctx_tid    (ctx_tid),
        .ctx_pc     (ctx_pc),
        .ctx_sp     (ctx_sp),
        .done_count (done_count)
    );

    ic_dispatch ic_dispatch_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .susp_push  (susp_push),
        .susp_tid   (susp_tid),
        .ic_ack     (ic_ack),
        .ic_switch  (ic_switch),
        .ic_ret_tid (ic_ret_tid),
        .ic_req     (ic_req),
        .ic_tid     (ic_tid),
        .back_push  (back_push),
        .back_tid   (back_tid)
    );

    patch_tracker patch_tracker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_last  (load_last),
        .load_pixel (load_pixel),
        .ready_tid  (ready_tid),
        .ctx_write  (ctx_write),
        .ctx_tid    (ctx_tid),
        .ctx_pc     (ctx_pc),
        .ctx_sp     (ctx_sp),
        .done_count (done_count),
        .loading    (loading),
        .load_push  (load_push),
        .load_tid   (load_tid),
        .rt_pixel   (rt_pixel),
        .rt_pc      (rt_pc),
        .rt_sp      (rt_sp),
        .patch_done (patch_done)
    );

endmodule

// File: hdl/patch_tracker.sv
`timescale 1ns/1ps

module patch_tracker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_valid,
    input  logic                                load_last,
    input  thread_ctx_pkg::pixel_id_t           load_pixel,
    input  thread_ctx_pkg::thread_id_t          ready_tid,
    input  logic                                ctx_write,
    input  thread_ctx_pkg::thread_id_t          ctx_tid,
    input  thread_ctx_pkg::addr_t               ctx_pc,
    input  thread_ctx_pkg::addr_t               ctx_sp,
    input  logic [dispatch_cfg_pkg::thread_w:0] done_count,
    output logic                                loading,
    output logic                                load_push,
    output thread_ctx_pkg::thread_id_t          load_tid,
    output thread_ctx_pkg::pixel_id_t           rt_pixel,
    output thread_ctx_pkg::addr_t               rt_pc,
    output thread_ctx_pkg::addr_t               rt_sp,
    output logic                                patch_done
);

    thread_ctx_pkg::load_state_e     state;
    thread_ctx_pkg::pixel_id_t       pixel_tab [dispatch_cfg_pkg::num_thread];
    thread_ctx_pkg::addr_t           pc_tab    [dispatch_cfg_pkg::num_thread];
    thread_ctx_pkg::addr_t           sp_tab    [dispatch_cfg_pkg::num_thread];
    logic [dispatch_cfg_pkg::thread_w:0] load_cnt;
    logic [dispatch_cfg_pkg::thread_w:0] done_cnt;
    logic                            new_patch;
    logic                            all_done;

    assign new_patch = load_valid && (state == thread_ctx_pkg::ld_idle);
    assign loading   = load_valid || (state == thread_ctx_pkg::ld_loading);
    assign load_push = load_valid;
    assign load_tid  = load_cnt[dispatch_cfg_pkg::thread_w-1:0];
    assign all_done  = (done_cnt != '0) && (done_cnt == load_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= thread_ctx_pkg::ld_idle;
            load_cnt   <= '0;
            done_cnt   <= '0;
            patch_done <= 1'b0;
        end else begin
            if (load_valid) begin
                state <= load_last ? thread_ctx_pkg::ld_idle : thread_ctx_pkg::ld_loading;
            end
            patch_done <= all_done;
            // clear both counts so the next patch restarts at thread 0
            if (all_done) begin
                load_cnt <= '0;
                done_cnt <= '0;
            end else begin
                load_cnt <= load_cnt + load_valid;
                done_cnt <= done_cnt + done_count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            pixel_tab[load_tid] <= load_pixel;
        end
    end

    // every thread restarts from its default context on a new patch
    always_ff @(posedge clk) begin
        if (new_patch) begin
            for (int t = 0; t < dispatch_cfg_pkg::num_thread; t++) begin
                pc_tab[t] <= dispatch_cfg_pkg::pc_reset;
                sp_tab[t] <= dispatch_cfg_pkg::sp_base + (32'(t) << 16);
            end
        end else if (ctx_write) begin
            pc_tab[ctx_tid] <= ctx_pc;
            sp_tab[ctx_tid] <= ctx_sp;
        end
    end

    assign rt_pixel = pixel_tab[ready_tid];
    assign rt_pc    = pc_tab[ready_tid];
    assign rt_sp    = sp_tab[ready_tid];

endmodule

// File: hdl/ic_dispatch.sv
`timescale 1ns/1ps

module ic_dispatch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       susp_push,
    input  thread_ctx_pkg::thread_id_t susp_tid,
    input  thread_ctx_pkg::ic_mask_t   ic_ack,
    input  thread_ctx_pkg::ic_mask_t   ic_switch,
    input  thread_ctx_pkg::thread_id_t ic_ret_tid [dispatch_cfg_pkg::num_ic],
    output thread_ctx_pkg::ic_mask_t   ic_req,
    output thread_ctx_pkg::thread_id_t ic_tid,
    output logic                       back_push,
    output thread_ctx_pkg::thread_id_t back_tid
);

    thread_ctx_pkg::disp_state_e state;
    thread_ctx_pkg::ic_mask_t    busy;
    thread_ctx_pkg::ic_mask_t    idle_core;
    thread_ctx_pkg::ic_mask_t    cur_core;
    thread_ctx_pkg::ic_mask_t    pend;
    thread_ctx_pkg::ic_mask_t    grant;
    thread_ctx_pkg::thread_id_t  tid_q;
    thread_ctx_pkg::thread_id_t  head_tid;
    thread_ctx_pkg::thread_id_t  pend_tid [dispatch_cfg_pkg::num_ic];
    logic                        empty;
    logic                        start;
    logic                        ack_hit;

    thread_fifo susp_q (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (susp_push),
        .push_tid (susp_tid),
        .pop      (start),
        .head_tid (head_tid),
        .empty    (empty),
        .full     ()
    );

    assign idle_core = ~busy & (busy + 1'b1);
    assign start     = (state == thread_ctx_pkg::disp_idle) && !empty && !(&busy);
    assign ack_hit   = |(ic_ack & cur_core);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= thread_ctx_pkg::disp_idle;
            cur_core <= '0;
            tid_q    <= '0;
        end else begin
            case (state)
                thread_ctx_pkg::disp_idle: begin
                    if (start) begin
                        cur_core <= idle_core;
                        tid_q    <= head_tid;
                        state    <= thread_ctx_pkg::disp_req_high;
                    end
                end
                thread_ctx_pkg::disp_req_high: begin
                    if (ack_hit) begin
                        state <= thread_ctx_pkg::disp_wait_ack_low;
                    end
                end
                default: begin
                    if (!ack_hit) begin
                        state <= thread_ctx_pkg::disp_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            pend <= '0;
        end else begin
            if (state == thread_ctx_pkg::disp_req_high && ack_hit) begin
                busy <= (busy | cur_core) & ~ic_switch;
            end else begin
                busy <= busy & ~ic_switch;
            end
            pend <= (pend & ~grant) | ic_switch;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < dispatch_cfg_pkg::num_ic; i++) begin
            if (ic_switch[i]) begin
                pend_tid[i] <= ic_ret_tid[i];
            end
        end
    end

    // one return per cycle, lowest core first
    assign grant = pend & (~pend + 1'b1);

    always_comb begin
        back_tid = '0;
        for (int i = 0; i < dispatch_cfg_pkg::num_ic; i++) begin
            back_tid |= {dispatch_cfg_pkg::thread_w{grant[i]}} & pend_tid[i];
        end
    end

    assign back_push = |pend;
    assign ic_req    = (state == thread_ctx_pkg::disp_req_high) ? cur_core : '0;
    assign ic_tid    = tid_q;

    assert property (@(posedge clk) disable iff (!rst_n) (ic_req & busy) == '0)
        else $error("ic_dispatch: request to a busy ic core");

endmodule

// File: hdl/rt_dispatch.sv
`timescale 1ns/1ps

module rt_dispatch (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_push,
    input  thread_ctx_pkg::thread_id_t      load_tid,
    input  logic                            loading,
    input  logic                            back_push,
    input  thread_ctx_pkg::thread_id_t      back_tid,
    input  thread_ctx_pkg::rt_mask_t        rt_ack,
    input  thread_ctx_pkg::rt_mask_t        rt_done,
    input  thread_ctx_pkg::rt_mask_t        rt_switch,
    input  thread_ctx_pkg::thread_id_t      rt_ret_tid [dispatch_cfg_pkg::num_rt],
    input  thread_ctx_pkg::addr_t           rt_ret_pc  [dispatch_cfg_pkg::num_rt],
    input  thread_ctx_pkg::addr_t           rt_ret_sp  [dispatch_cfg_pkg::num_rt],
    output thread_ctx_pkg::rt_mask_t        rt_req,
    output thread_ctx_pkg::thread_id_t      rt_tid,
    output thread_ctx_pkg::thread_id_t      ready_tid,
    output logic                            susp_push,
    output thread_ctx_pkg::thread_id_t      susp_tid,
    output logic                            ctx_write,
    output thread_ctx_pkg::thread_id_t      ctx_tid,
    output thread_ctx_pkg::addr_t           ctx_pc,
    output thread_ctx_pkg::addr_t           ctx_sp,
    output logic [dispatch_cfg_pkg::thread_w:0] done_count
);

    thread_ctx_pkg::disp_state_e state;
    thread_ctx_pkg::rt_mask_t    busy;
    thread_ctx_pkg::rt_mask_t    idle_core;
    thread_ctx_pkg::rt_mask_t    cur_core;
    thread_ctx_pkg::rt_mask_t    pend;
    thread_ctx_pkg::rt_mask_t    grant;
    thread_ctx_pkg::thread_id_t  tid_q;
    thread_ctx_pkg::thread_id_t  head_tid;
    thread_ctx_pkg::thread_id_t  pend_tid [dispatch_cfg_pkg::num_rt];
    thread_ctx_pkg::addr_t       pend_pc  [dispatch_cfg_pkg::num_rt];
    thread_ctx_pkg::addr_t       pend_sp  [dispatch_cfg_pkg::num_rt];
    logic                        empty;
    logic                        start;
    logic                        ack_hit;

    // loaded threads win over ic returns
    thread_fifo ready_q (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (load_push | back_push),
        .push_tid (load_push ? load_tid : back_tid),
        .pop      (start),
        .head_tid (head_tid),
        .empty    (empty),
        .full     ()
    );

    // lowest idle core
    assign idle_core = ~busy & (busy + 1'b1);
    assign start     = (state == thread_ctx_pkg::disp_idle) && !loading && !empty && !(&busy);
    assign ack_hit   = |(rt_ack & cur_core);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= thread_ctx_pkg::disp_idle;
            cur_core <= '0;
            tid_q    <= '0;
        end else begin
            case (state)
                thread_ctx_pkg::disp_idle: begin
                    if (start) begin
                        cur_core <= idle_core;
                        tid_q    <= head_tid;
                        state    <= thread_ctx_pkg::disp_req_high;
                    end
                end
                thread_ctx_pkg::disp_req_high: begin
                    if (ack_hit) begin
                        state <= thread_ctx_pkg::disp_wait_ack_low;
                    end
                end
                default: begin
                    if (!ack_hit) begin
                        state <= thread_ctx_pkg::disp_idle;
                    end
                end
            endcase
        end
    end

    // busy from ack until the core returns the thread
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else if (state == thread_ctx_pkg::disp_req_high && ack_hit) begin
            busy <= (busy | cur_core) & ~(rt_done | rt_switch);
        end else begin
            busy <= busy & ~(rt_done | rt_switch);
        end
    end

    assign rt_req    = (state == thread_ctx_pkg::disp_req_high) ? cur_core : '0;
    assign rt_tid    = tid_q;
    assign ready_tid = tid_q;

    // switch returns wait here until merged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~grant) | rt_switch;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < dispatch_cfg_pkg::num_rt; i++) begin
            if (rt_switch[i]) begin
                pend_tid[i] <= rt_ret_tid[i];
                pend_pc[i]  <= rt_ret_pc[i];
                pend_sp[i]  <= rt_ret_sp[i];
            end
        end
    end

    assign grant = pend & (~pend + 1'b1);

    always_comb begin
        susp_tid   = '0;
        ctx_pc     = '0;
        ctx_sp     = '0;
        done_count = '0;
        for (int i = 0; i < dispatch_cfg_pkg::num_rt; i++) begin
            susp_tid   |= {dispatch_cfg_pkg::thread_w{grant[i]}} & pend_tid[i];
            ctx_pc     |= {32{grant[i]}} & pend_pc[i];
            ctx_sp     |= {32{grant[i]}} & pend_sp[i];
            done_count += {{dispatch_cfg_pkg::thread_w{1'b0}}, rt_done[i]};
        end
    end

    assign susp_push = |pend;
    assign ctx_write = susp_push;
    assign ctx_tid   = susp_tid;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rt_req))
        else $error("rt_dispatch: rt_req not one-hot");
    // ic returns never coincide with a patch load
    assert property (@(posedge clk) disable iff (!rst_n) !(load_push && back_push))
        else $error("rt_dispatch: ic return lost to load push");

endmodule

// File: hdl/thread_fifo.sv
`timescale 1ns/1ps

module thread_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  thread_ctx_pkg::thread_id_t push_tid,
    input  logic                       pop,
    output thread_ctx_pkg::thread_id_t head_tid,
    output logic                       empty,
    output logic                       full
);

    thread_ctx_pkg::thread_id_t mem [dispatch_cfg_pkg::num_thread];
    thread_ctx_pkg::thread_id_t wr_ptr;
    thread_ctx_pkg::thread_id_t rd_ptr;
    logic [dispatch_cfg_pkg::thread_w:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_tid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_tid = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == (dispatch_cfg_pkg::thread_w + 1)'(dispatch_cfg_pkg::num_thread));

    // depth covers a whole patch
    assert property (@(posedge clk) disable iff (!rst_n) !(push && full && !pop))
        else $error("thread_fifo: push while full");
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("thread_fifo: pop while empty");

endmodule

// File: hdl/thread_ctx_pkg.sv
package thread_ctx_pkg;

    typedef logic [dispatch_cfg_pkg::thread_w-1:0] thread_id_t;
    typedef logic [31:0] pixel_id_t;
    typedef logic [31:0] addr_t;

    // one bit per core
    typedef logic [dispatch_cfg_pkg::num_rt-1:0] rt_mask_t;
    typedef logic [dispatch_cfg_pkg::num_ic-1:0] ic_mask_t;

    typedef enum logic {
        ld_idle,
        ld_loading
    } load_state_e;

    // four-phase req/ack toward a core
    typedef enum logic [1:0] {
        disp_idle,
        disp_req_high,
        disp_wait_ack_low
    } disp_state_e;

endpackage

// File: hdl/dispatch_cfg_pkg.sv
package dispatch_cfg_pkg;

    // cluster size
    localparam int num_rt = 4;
    localparam int num_ic = 2;

    // one thread per pixel of a patch
    localparam int num_thread = 16;
    localparam int thread_w   = 4;

    // thread t starts at pc 0, sp = sp_base + (t << 16)
    localparam logic [31:0] sp_base  = 32'h8000_0000;
    localparam logic [31:0] pc_reset = 32'h0000_0000;

endpackage
